// File: tb.f
+incdir+tests
src/mem_pkg.sv
src/mem_addr_gen.sv
src/store_align.sv
src/strand_ctrl.sv
src/mem_stage_reg.sv
src/mem_access_stage.sv
tests/tb_mem_access.sv

// File: Makefile
# Verilator build and run of the memory access stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_access
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/mem_access_vectors.svh
/*
 * Access check table
 * One row per combinational access: inputs and the expected address,
 * strobes, byte write mask and replicated data word
 */
`ifndef MEM_ACCESS_VECTORS_SVH
`define MEM_ACCESS_VECTORS_SVH

typedef struct {
	string       name;
	logic [3:0]  op;
	logic        is_load;
	logic [31:0] store_word;	// Placed in lane sel
	logic [31:0] ptr;	// Lane sel for scatter, lane 15 otherwise
	logic [31:0] base;
	logic [31:0] offset;
	logic [15:0] mask;
	logic [3:0]  sel;
	logic [31:0] exp_addr;
	logic        exp_access;
	logic        exp_write;
	logic [63:0] exp_wmask;
	logic [31:0] exp_pattern;
} vec_t;

vec_t vec_q[$];

task automatic add_vec(input string name, input logic [3:0] op, input logic ld,
	input logic [31:0] sw, input logic [31:0] ptr, input logic [31:0] base,
	input logic [31:0] offset, input logic [15:0] mask, input logic [3:0] sel,
	input logic [31:0] addr, input logic acc, input logic wr, input logic [63:0] wm,
	input logic [31:0] pat);
	vec_t v;
	v = '{name, op, ld, sw, ptr, base, offset, mask, sel, addr, acc, wr, wm, pat};
	vec_q.push_back(v);
endtask

task automatic fill_table();
	add_vec("byte_off0", 4'd0, 0, 32'h0000_00a5, 32'h0000_1044, 0, 0, 16'hffff, 15,
		32'h0000_1040, 1, 1, 64'h0800_0000_0000_0000, 32'ha500_0000);
	add_vec("byte_off1", 4'd1, 0, 32'h0000_00a5, 32'h0000_1045, 0, 0, 16'hffff, 15,
		32'h0000_1040, 1, 1, 64'h0400_0000_0000_0000, 32'h00a5_0000);
	add_vec("byte_off2", 4'd0, 0, 32'h0000_00a5, 32'h0000_1046, 0, 0, 16'hffff, 15,
		32'h0000_1040, 1, 1, 64'h0200_0000_0000_0000, 32'h0000_a500);
	add_vec("byte_off3", 4'd1, 0, 32'h0000_00a5, 32'h0000_1047, 0, 0, 16'hffff, 15,
		32'h0000_1040, 1, 1, 64'h0100_0000_0000_0000, 32'h0000_00a5);
	add_vec("half_hi", 4'd2, 0, 32'h0000_1234, 32'h0000_2078, 0, 0, 16'hffff, 15,
		32'h0000_2040, 1, 1, 64'h0000_0000_0000_00c0, 32'h3412_0000);
	add_vec("half_lo", 4'd3, 0, 32'h0000_1234, 32'h0000_207a, 0, 0, 16'hffff, 15,
		32'h0000_2040, 1, 1, 64'h0000_0000_0000_0030, 32'h0000_3412);
	add_vec("word", 4'd4, 0, 32'hdead_beef, 32'h3000_003c, 0, 0, 16'hffff, 15,
		32'h3000_0000, 1, 1, 64'h0000_0000_0000_000f, 32'hefbe_adde);
	add_vec("strided", 4'd10, 0, 32'h1122_3344, 32'h0, 32'h4000_0000, 32'h108, 16'hffff, 3,
		32'h4000_0100, 1, 1, 64'h00f0_0000_0000_0000, 32'h4433_2211);
	add_vec("scatter", 4'd13, 0, 32'hcafe_f00d, 32'h5000_0024, 0, 0, 16'hffff, 5,
		32'h5000_0000, 1, 1, 64'h0000_0000_0f00_0000, 32'h0df0_feca);
	add_vec("scatter_off", 4'd13, 0, 32'hcafe_f00d, 32'h5000_0024, 0, 0, 16'hfbff, 5,
		32'h5000_0000, 0, 1, 64'h0, 32'h0df0_feca);
	add_vec("load_word", 4'd4, 1, 32'h0, 32'h6000_0010, 0, 0, 16'hffff, 15,
		32'h6000_0000, 1, 0, 64'h0000_f000_0000_0000, 32'h0);
endtask

`endif

// File: tests/tb_mem_access.sv
/*
 * Testbench for the memory access stage
 * Table driven access checks, control registers, store buffer full
 * rollback, pipeline register and flush
 */
module tb_mem_access;
	timeunit 1ns;
	timeprecision 100ps;

	logic         clk;
	logic         rst_n_i;
	logic [31:0]  instruction_i;
	logic [1:0]   strand_id_i;
	logic [31:0]  pc_i;
	logic [511:0] store_value_i;
	logic [511:0] result_i;
	logic [15:0]  mask_i;
	logic [3:0]   reg_lane_select_i;
	logic [31:0]  base_addr_i;
	logic [31:0]  strided_offset_i;
	logic         has_writeback_i;
	logic [6:0]   writeback_reg_i;
	logic         writeback_is_vector_i;
	logic         flush_i;
	logic         dstbuf_full_i;
	logic [3:0]   load_complete_strands_i;
	logic [31:0]  daddress_o;
	logic         daccess_o;
	logic         dwrite_o;
	logic [511:0] ddata_o;
	logic [63:0]  write_mask_o;
	logic         rollback_request_o;
	logic [31:0]  rollback_address_o;
	logic         suspend_request_o;
	logic [3:0]   resume_strand_o;
	logic [3:0]   strand_enable_o;
	logic [31:0]  instruction_o;
	logic [1:0]   strand_id_o;
	logic [31:0]  pc_o;
	logic [511:0] result_o;
	logic [15:0]  mask_o;
	logic [3:0]   reg_lane_select_o;
	logic [3:0]   cache_lane_select_o;
	logic         was_access_o;
	logic         has_writeback_o;
	logic [6:0]   writeback_reg_o;
	logic         writeback_is_vector_o;
	logic [31:0]  strided_offset_o;
	int           errors;

	`include "mem_access_vectors.svh"

	mem_access_stage i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Last resort if the run stalls
	initial
	begin
		#2_000_000;
		$display("Simulation timed out before the end of the checks");
		$display("Some tests failed");
		$finish;
	end

	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Format-C word: fmt, load or read flag, op, cr index
	function automatic logic [31:0] make_instr(input logic [3:0] op, input logic ld,
		input logic [4:0] idx);
		return {2'b10, ld, op, 20'd0, idx};
	endfunction

	// Lane 0 is the top word; other lanes get random filler
	function automatic logic [511:0] make_line(input logic [31:0] word, input logic [3:0] lane);
		logic [511:0] line;
		for (int i = 0; i < 16; i++)
			line[(15 - i) * 32 +: 32] = (i == int'(lane)) ? word : $urandom();
		return line;
	endfunction

	task automatic report_mismatch(input string name, input logic [511:0] exp,
		input logic [511:0] act);
		$display("MISMATCH %s expected %0h actual %0h", name, exp, act);
		errors++;
	endtask

	task automatic drive_idle();
		instruction_i           = '0;
		strand_id_i             = '0;
		pc_i                    = '0;
		store_value_i           = '0;
		result_i                = '0;
		mask_i                  = 16'hffff;
		reg_lane_select_i       = 4'd15;
		base_addr_i             = '0;
		strided_offset_i        = '0;
		has_writeback_i         = 1'b0;
		writeback_reg_i         = '0;
		writeback_is_vector_i   = 1'b0;
		flush_i                 = 1'b0;
		dstbuf_full_i           = 1'b0;
		load_complete_strands_i = '0;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic wait_rollback(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (rollback_request_o !== 1'b1 && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (rollback_request_o !== 1'b1)
		begin
			$display("Rollback request never rose for the store into a full buffer");
			errors++;
		end
	endtask

	task automatic wait_resume(input logic [3:0] want, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while ((resume_strand_o & want) !== want && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if ((resume_strand_o & want) !== want)
		begin
			$display("Resume never named the waiting strands %b", want);
			errors++;
		end
	endtask

	task automatic run_table();
		vec_t v;
		logic [3:0] plane;
		foreach (vec_q[i])
		begin
			v = vec_q[i];
			plane = (v.op >= 4'd13) ? v.sel : 4'd15;
			next_cycle();
			drive_idle();
			instruction_i     = make_instr(v.op, v.is_load, 5'd0);
			store_value_i     = make_line(v.store_word, v.sel);
			result_i          = make_line(v.ptr, plane);
			base_addr_i       = v.base;
			strided_offset_i  = v.offset;
			mask_i            = v.mask;
			reg_lane_select_i = v.sel;
			@(negedge clk);
			if (daddress_o !== v.exp_addr)
				report_mismatch({v.name, " daddress"}, v.exp_addr, daddress_o);
			if (daccess_o !== v.exp_access)
				report_mismatch({v.name, " daccess"}, v.exp_access, daccess_o);
			if (dwrite_o !== v.exp_write)
				report_mismatch({v.name, " dwrite"}, v.exp_write, dwrite_o);
			if (write_mask_o !== v.exp_wmask)
				report_mismatch({v.name, " write_mask"}, v.exp_wmask, write_mask_o);
			if (ddata_o !== {16{v.exp_pattern}})
				report_mismatch({v.name, " ddata"}, {16{v.exp_pattern}}, ddata_o);
		end
	endtask

	task automatic check_block();
		logic [511:0] exp_data;
		logic [63:0]  exp_mask;
		next_cycle();
		drive_idle();
		instruction_i = make_instr(4'd7, 1'b0, 5'd0);
		store_value_i = make_line($urandom(), 4'd0);
		result_i      = {480'd0, 32'h7000_0000};
		mask_i        = 16'ha50f;
		for (int i = 0; i < 16; i++)
		begin
			exp_data[i * 32 +: 32] = swap_bytes(store_value_i[i * 32 +: 32]);
			exp_mask[i * 4 +: 4]   = {4{mask_i[i]}};
		end
		@(negedge clk);
		if (daddress_o !== 32'h7000_0000)
			report_mismatch("block daddress", 32'h7000_0000, daddress_o);
		if (daccess_o !== 1'b1 || dwrite_o !== 1'b1)
			report_mismatch("block strobes", 2'b11, {daccess_o, dwrite_o});
		if (write_mask_o !== exp_mask)
			report_mismatch("block write_mask", exp_mask, write_mask_o);
		if (ddata_o !== exp_data)
			report_mismatch("block ddata", exp_data, ddata_o);
	endtask

	task automatic cr_access(input string name, input logic rd, input logic [4:0] idx,
		input logic [31:0] value);
		next_cycle();
		drive_idle();
		instruction_i       = make_instr(4'd6, rd, idx);
		store_value_i[31:0] = value;
		strand_id_i         = 2'd2;
		@(negedge clk);
		if (dwrite_o !== 1'b0 || daccess_o !== 1'b0)
			report_mismatch({name, " strobes"}, 2'b00, {daccess_o, dwrite_o});
	endtask

	task automatic check_cr_read(input string name, input logic [4:0] idx,
		input logic [31:0] exp);
		cr_access(name, 1'b1, idx, 32'h0);
		@(negedge clk);
		if (result_o !== {480'd0, exp})
			report_mismatch(name, {480'd0, exp}, result_o);
	endtask

	initial
	begin
		logic [3:0] saved_en;
		logic [31:0] instr;
		errors = 0;
		void'($urandom(65512));
		rst_n_i = 1'b0;
		drive_idle();
		fill_table();
		repeat (16) @(posedge clk);
		#2;
		rst_n_i = 1'b1;
		@(negedge clk);
		if (strand_enable_o !== 4'b0001)
			report_mismatch("reset strand_enable", 4'b0001, strand_enable_o);
		if (was_access_o !== 1'b0)
			report_mismatch("reset was_access", 1'b0, was_access_o);
		if (result_o !== '0)
			report_mismatch("reset result", '0, result_o);

		run_table();
		check_block();

		cr_access("write test", 1'b0, 5'd7, 32'h5a5a_1234);
		check_cr_read("read test", 5'd7, 32'h5a5a_1234);
		cr_access("write enable", 1'b0, 5'd30, 32'h0000_000b);
		@(negedge clk);
		if (strand_enable_o !== 4'b1011)
			report_mismatch("strand_enable", 4'b1011, strand_enable_o);
		check_cr_read("read enable", 5'd30, 32'h0000_000b);
		check_cr_read("read strand id", 5'd0, {mem_pkg::CORE_ID, 2'd2});
		cr_access("halt", 1'b0, 5'd31, 32'h0);
		@(negedge clk);
		if (strand_enable_o !== 4'b0000)
			report_mismatch("halt strand_enable", 4'b0000, strand_enable_o);

		// Store into a full buffer from strand 2
		next_cycle();
		drive_idle();
		instruction_i = make_instr(4'd4, 1'b0, 5'd0);
		strand_id_i   = 2'd2;
		pc_i          = 32'h0000_0100;
		dstbuf_full_i = 1'b1;
		wait_rollback(4);
		if (suspend_request_o !== 1'b1)
			report_mismatch("suspend", 1'b1, suspend_request_o);
		if (rollback_address_o !== 32'h0000_00fc)
			report_mismatch("rollback address", 32'h0000_00fc, rollback_address_o);
		next_cycle();
		drive_idle();
		load_complete_strands_i = 4'b0001;
		wait_resume(4'b0101, 4);

		// Registered path with random contents
		for (int i = 0; i < 8; i++)
		begin
			next_cycle();
			drive_idle();
			instr                 = {2'b10, 1'b1, 4'd4, 25'($urandom())};
			instruction_i         = instr;
			strand_id_i           = 2'($urandom());
			pc_i                  = $urandom();
			result_i              = make_line($urandom(), 4'd15);
			mask_i                = 16'($urandom());
			reg_lane_select_i     = 4'($urandom());
			has_writeback_i       = 1'($urandom());
			writeback_reg_i       = 7'($urandom());
			writeback_is_vector_i = 1'($urandom());
			strided_offset_i      = $urandom();
			@(posedge clk);	// Captured here
			@(negedge clk);
			if (instruction_o !== instr || pc_o !== pc_i || strand_id_o !== strand_id_i)
				report_mismatch("pipe control", {instr, pc_i}, {instruction_o, pc_o});
			if (result_o !== result_i || mask_o !== mask_i)
				report_mismatch("pipe data", result_i, result_o);
			if (cache_lane_select_o !== result_i[5:2] || reg_lane_select_o !== reg_lane_select_i)
				report_mismatch("pipe lanes", result_i[5:2], cache_lane_select_o);
			if (writeback_reg_o !== writeback_reg_i || has_writeback_o !== has_writeback_i
				|| writeback_is_vector_o !== writeback_is_vector_i)
				report_mismatch("pipe writeback", writeback_reg_i, writeback_reg_o);
			// Lane 0 owns the top mask bit
			if (was_access_o !== mask_i[15 - int'(reg_lane_select_i)])
				report_mismatch("pipe was_access", mask_i[15 - int'(reg_lane_select_i)],
					was_access_o);
			if (strided_offset_o !== strided_offset_i)
				report_mismatch("pipe offset", strided_offset_i, strided_offset_o);
		end

		// Flush kills the store and the control register write
		saved_en = strand_enable_o;
		next_cycle();
		drive_idle();
		instruction_i = make_instr(4'd4, 1'b0, 5'd0);
		pc_i          = 32'h0000_0200;
		flush_i       = 1'b1;
		@(negedge clk);
		if (dwrite_o !== 1'b0 || daccess_o !== 1'b0)
			report_mismatch("flush strobes", 2'b00, {daccess_o, dwrite_o});
		next_cycle();
		instruction_i       = make_instr(4'd6, 1'b0, 5'd30);
		store_value_i[31:0] = 32'hf;
		@(negedge clk);
		if (instruction_o !== '0 || pc_o !== '0 || result_o !== '0 || was_access_o !== 1'b0)
			report_mismatch("flush registers", 0, {instruction_o, pc_o});
		next_cycle();
		drive_idle();
		@(negedge clk);
		if (strand_enable_o !== saved_en)
			report_mismatch("flush strand_enable", saved_en, strand_enable_o);

		$display("Checks done, error count %0d", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end
endmodule

// File: src/mem_access_stage.sv
/*
 * Memory access stage of the vector core
 * Issues data cache reads and writes and registers results for writeback
 */
module mem_access_stage (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  mem_pkg::instr_u               instruction_i,
	input  logic [1:0]                    strand_id_i,
	input  logic [31:0]                   pc_i,
	input  logic [mem_pkg::LINE_W-1:0]    store_value_i,
	input  logic [mem_pkg::LINE_W-1:0]    result_i,
	input  logic [mem_pkg::LANES-1:0]     mask_i,
	input  logic [3:0]                    reg_lane_select_i,
	input  logic [31:0]                   base_addr_i,
	input  logic [31:0]                   strided_offset_i,
	input  logic                          has_writeback_i,
	input  logic [6:0]                    writeback_reg_i,
	input  logic                          writeback_is_vector_i,
	input  logic                          flush_i,
	input  logic                          dstbuf_full_i,
	input  logic [mem_pkg::STRANDS-1:0]   load_complete_strands_i,
	output logic [31:0]                   daddress_o,
	output logic                          daccess_o,
	output logic                          dwrite_o,
	output logic [mem_pkg::LINE_W-1:0]    ddata_o,
	output logic [mem_pkg::MASK_W-1:0]    write_mask_o,
	output logic                          rollback_request_o,
	output logic [31:0]                   rollback_address_o,
	output logic                          suspend_request_o,
	output logic [mem_pkg::STRANDS-1:0]   resume_strand_o,
	output logic [mem_pkg::STRANDS-1:0]   strand_enable_o,
	output logic [31:0]                   instruction_o,
	output logic [1:0]                    strand_id_o,
	output logic [31:0]                   pc_o,
	output logic [mem_pkg::LINE_W-1:0]    result_o,
	output logic [mem_pkg::LANES-1:0]     mask_o,
	output logic [3:0]                    reg_lane_select_o,
	output logic [3:0]                    cache_lane_select_o,
	output logic                          was_access_o,
	output logic                          has_writeback_o,
	output logic [6:0]                    writeback_reg_o,
	output logic                          writeback_is_vector_o,
	output logic [31:0]                   strided_offset_o
);
	logic [3:0]  cache_lane_nxt;
	logic        lane_active;
	logic [31:0] test_reg;

	mem_addr_gen i_addr_gen (
		.instruction_i, .flush_i, .mask_i, .reg_lane_select_i, .result_i,
		.base_addr_i, .strided_offset_i, .daddress_o,
		.cache_lane_nxt_o (cache_lane_nxt),
		.daccess_o,
		.lane_active_o    (lane_active)
	);

	store_align i_store_align (
		.instruction_i, .flush_i, .store_value_i,
		.result_i         (result_i[1:0]),
		.reg_lane_select_i,
		.cache_lane_nxt_i (cache_lane_nxt),
		.lane_active_i    (lane_active),
		.mask_i, .dwrite_o, .ddata_o, .write_mask_o
	);

	strand_ctrl i_strand_ctrl (
		.clk, .rst_n_i, .instruction_i, .flush_i, .strand_id_i, .pc_i,
		.store_value_i    (store_value_i[31:0]),
		.daccess_i        (daccess_o),
		.dstbuf_full_i, .load_complete_strands_i, .rollback_request_o,
		.rollback_address_o, .suspend_request_o, .resume_strand_o, .strand_enable_o,
		.test_reg_o       (test_reg)
	);

	mem_stage_reg i_stage_reg (
		.clk, .rst_n_i, .flush_i, .instruction_i, .strand_id_i, .pc_i, .result_i,
		.mask_i, .reg_lane_select_i,
		.cache_lane_nxt_i (cache_lane_nxt),
		.daccess_i        (daccess_o),
		.has_writeback_i, .writeback_reg_i, .writeback_is_vector_i, .strided_offset_i,
		.test_reg_i       (test_reg),
		.strand_enable_i  (strand_enable_o),
		.instruction_o, .strand_id_o, .pc_o, .result_o, .mask_o, .reg_lane_select_o,
		.cache_lane_select_o, .was_access_o, .has_writeback_o, .writeback_reg_o,
		.writeback_is_vector_o, .strided_offset_o
	);
endmodule

// File: src/mem_stage_reg.sv
/*
 * Memory stage output register
 * Picks the control register read value and registers the
 * stage results for writeback, cleared on flush
 */
module mem_stage_reg (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic                          flush_i,
	input  mem_pkg::instr_u               instruction_i,
	input  logic [1:0]                    strand_id_i,
	input  logic [31:0]                   pc_i,
	input  logic [mem_pkg::LINE_W-1:0]    result_i,
	input  logic [mem_pkg::LANES-1:0]     mask_i,
	input  logic [3:0]                    reg_lane_select_i,
	input  logic [3:0]                    cache_lane_nxt_i,
	input  logic                          daccess_i,
	input  logic                          has_writeback_i,
	input  logic [6:0]                    writeback_reg_i,
	input  logic                          writeback_is_vector_i,
	input  logic [31:0]                   strided_offset_i,
	input  logic [31:0]                   test_reg_i,
	input  logic [mem_pkg::STRANDS-1:0]   strand_enable_i,
	output logic [31:0]                   instruction_o,
	output logic [1:0]                    strand_id_o,
	output logic [31:0]                   pc_o,
	output logic [mem_pkg::LINE_W-1:0]    result_o,
	output logic [mem_pkg::LANES-1:0]     mask_o,
	output logic [3:0]                    reg_lane_select_o,
	output logic [3:0]                    cache_lane_select_o,
	output logic                          was_access_o,
	output logic                          has_writeback_o,
	output logic [6:0]                    writeback_reg_o,
	output logic                          writeback_is_vector_o,
	output logic [31:0]                   strided_offset_o
);
	logic                       is_cr_read;
	logic [mem_pkg::LINE_W-1:0] result_nxt;

	assign is_cr_read = instruction_i.cr.fmt == mem_pkg::FMT_C
		&& instruction_i.cr.op_type == mem_pkg::OP_CTRL && instruction_i.cr.is_read;

	always_comb
	begin
		result_nxt = result_i;
		if (is_cr_read)
		begin
			result_nxt = '0;
			case (instruction_i.cr.cr_index)
				mem_pkg::CR_STRAND_ID: result_nxt[31:0] = {mem_pkg::CORE_ID, strand_id_i};
				mem_pkg::CR_TEST:      result_nxt[31:0] = test_reg_i;
				mem_pkg::CR_STRAND_EN: result_nxt[mem_pkg::STRANDS-1:0] = strand_enable_i;
				default: ;	// Unknown registers read as zero
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			instruction_o         <= '0;
			strand_id_o           <= '0;
			pc_o                  <= '0;
			result_o              <= '0;
			mask_o                <= '0;
			reg_lane_select_o     <= '0;
			cache_lane_select_o   <= '0;
			was_access_o          <= 1'b0;
			has_writeback_o       <= 1'b0;
			writeback_reg_o       <= '0;
			writeback_is_vector_o <= 1'b0;
			strided_offset_o      <= '0;
		end
		else if (flush_i)
		begin
			instruction_o         <= '0;
			strand_id_o           <= '0;
			pc_o                  <= '0;
			result_o              <= '0;
			mask_o                <= '0;
			reg_lane_select_o     <= '0;
			cache_lane_select_o   <= '0;
			was_access_o          <= 1'b0;
			has_writeback_o       <= 1'b0;
			writeback_reg_o       <= '0;
			writeback_is_vector_o <= 1'b0;
			strided_offset_o      <= '0;
		end
		else
		begin
			instruction_o         <= instruction_i;
			strand_id_o           <= strand_id_i;
			pc_o                  <= pc_i;
			result_o              <= result_nxt;
			mask_o                <= mask_i;
			reg_lane_select_o     <= reg_lane_select_i;
			cache_lane_select_o   <= cache_lane_nxt_i;
			was_access_o          <= daccess_i;
			has_writeback_o       <= has_writeback_i;
			writeback_reg_o       <= writeback_reg_i;
			writeback_is_vector_o <= writeback_is_vector_i;
			strided_offset_o      <= strided_offset_i;
		end
	end
endmodule

// File: src/strand_ctrl.sv
/*
 * Strand control
 * Control registers, store-wait strand set and the rollback,
 * suspend and resume signals for a full store buffer
 */
module strand_ctrl (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  mem_pkg::instr_u               instruction_i,
	input  logic                          flush_i,
	input  logic [1:0]                    strand_id_i,
	input  logic [31:0]                   pc_i,
	input  logic [31:0]                   store_value_i,
	input  logic                          daccess_i,
	input  logic                          dstbuf_full_i,
	input  logic [mem_pkg::STRANDS-1:0]   load_complete_strands_i,
	output logic                          rollback_request_o,
	output logic [31:0]                   rollback_address_o,
	output logic                          suspend_request_o,
	output logic [mem_pkg::STRANDS-1:0]   resume_strand_o,
	output logic [mem_pkg::STRANDS-1:0]   strand_enable_o,
	output logic [31:0]                   test_reg_o
);
	logic                        is_cr_write;
	logic [mem_pkg::STRANDS-1:0] wait_set;

	assign is_cr_write = !flush_i && instruction_i.cr.fmt == mem_pkg::FMT_C
		&& instruction_i.cr.op_type == mem_pkg::OP_CTRL && !instruction_i.cr.is_read;

	// Store hit a full buffer, so replay it later
	assign rollback_request_o = daccess_i && !instruction_i.mem.is_load && dstbuf_full_i;
	assign suspend_request_o  = rollback_request_o;
	assign rollback_address_o = pc_i - 32'd4;
	assign resume_strand_o    = load_complete_strands_i | (dstbuf_full_i ? '0 : wait_set);

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			test_reg_o      <= '0;
			strand_enable_o <= 4'b0001;	// Only strand 0 runs out of reset
		end
		else if (is_cr_write)
		begin
			case (instruction_i.cr.cr_index)
				mem_pkg::CR_TEST:      test_reg_o <= store_value_i;
				mem_pkg::CR_STRAND_EN: strand_enable_o <= store_value_i[mem_pkg::STRANDS-1:0];
				mem_pkg::CR_HALT:      strand_enable_o <= '0;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			wait_set <= '0;
		else if (rollback_request_o)
			wait_set <= wait_set | (mem_pkg::STRANDS'(1) << strand_id_i);
		else if (!dstbuf_full_i)
			wait_set <= '0;	// Buffer drained
	end
endmodule

// File: src/store_align.sv
/*
 * Store data alignment
 * Puts store data into big-endian byte order across the line
 * and builds the word and byte write masks
 */
module store_align (
	input  mem_pkg::instr_u              instruction_i,
	input  logic                         flush_i,
	input  logic [mem_pkg::LINE_W-1:0]   store_value_i,
	input  logic [1:0]                   result_i,
	input  logic [3:0]                   reg_lane_select_i,
	input  logic [3:0]                   cache_lane_nxt_i,
	input  logic                         lane_active_i,
	input  logic [mem_pkg::LANES-1:0]    mask_i,
	output logic                         dwrite_o,
	output logic [mem_pkg::LINE_W-1:0]   ddata_o,
	output logic [mem_pkg::MASK_W-1:0]   write_mask_o
);
	logic [3:0]                  op;
	logic                        is_block;
	logic                        is_lane_op;
	logic [mem_pkg::WORD_W-1:0]  lane_value;
	logic [mem_pkg::WORD_W-1:0]  pattern;
	logic [3:0]                  byte_mask;
	logic [mem_pkg::LINE_W-1:0]  swapped;
	logic [mem_pkg::LANES-1:0]   lane_onehot;
	logic [mem_pkg::LANES-1:0]   word_mask;

	function automatic logic [31:0] bswap(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign op         = instruction_i.mem.op_type;
	assign is_block   = op inside {[mem_pkg::OP_BLOCK_LO:mem_pkg::OP_BLOCK_HI]};
	assign is_lane_op = op inside {[mem_pkg::OP_STRIDED_LO:mem_pkg::OP_SCATTER_HI]};
	assign lane_value = mem_pkg::lane_pick(store_value_i, reg_lane_select_i);

	// Still raised with the store buffer full, so the cache skips its load
	assign dwrite_o = instruction_i.mem.fmt == mem_pkg::FMT_C && !instruction_i.mem.is_load
		&& op != mem_pkg::OP_CTRL && !flush_i;

	always_comb
	begin
		for (int i = 0; i < mem_pkg::LANES; i++)
			swapped[i * mem_pkg::WORD_W +: mem_pkg::WORD_W] =
				bswap(store_value_i[i * mem_pkg::WORD_W +: mem_pkg::WORD_W]);
	end

	always_comb
	begin
		byte_mask = 4'b1111;
		pattern   = bswap(lane_value);	// Strided and scatter
		case (op)
			mem_pkg::OP_BYTE, mem_pkg::OP_BYTE_S:
			begin
				byte_mask = 4'b1000 >> result_i;
				pattern   = {store_value_i[7:0], 24'd0} >> {result_i, 3'b000};
			end
			mem_pkg::OP_HALF, mem_pkg::OP_HALF_S:
			begin
				byte_mask = result_i[1] ? 4'b0011 : 4'b1100;
				pattern   = {store_value_i[7:0], store_value_i[15:8], 16'd0} >> {result_i[1], 4'd0};
			end
			mem_pkg::OP_WORD, mem_pkg::OP_WORD_S, mem_pkg::OP_CTRL:
				pattern = bswap(store_value_i[31:0]);
			default: ;
		endcase
	end

	assign ddata_o = is_block ? swapped : {mem_pkg::LANES{pattern}};

	always_comb
	begin
		lane_onehot = '0;
		lane_onehot[~cache_lane_nxt_i] = 1'b1;	// Lane 0 is the top bit
		if (is_block)
			word_mask = mask_i;
		else if (is_lane_op)
			word_mask = lane_active_i ? lane_onehot : '0;
		else
			word_mask = lane_onehot;
	end

	// Word mask crossed with byte mask
	always_comb
	begin
		for (int i = 0; i < mem_pkg::LANES; i++)
			write_mask_o[i * 4 +: 4] = word_mask[i] ? byte_mask : 4'b0000;
	end
endmodule

// File: src/mem_addr_gen.sv
/*
 * Memory address generation
 * Picks the pointer for scalar, block, strided and scatter/gather
 * accesses and forms the line address, cache lane and access strobe
 */
module mem_addr_gen (
	input  mem_pkg::instr_u              instruction_i,
	input  logic                         flush_i,
	input  logic [mem_pkg::LANES-1:0]    mask_i,
	input  logic [3:0]                   reg_lane_select_i,
	input  logic [mem_pkg::LINE_W-1:0]   result_i,
	input  logic [31:0]                  base_addr_i,
	input  logic [31:0]                  strided_offset_i,
	output logic [31:0]                  daddress_o,
	output logic [3:0]                   cache_lane_nxt_o,
	output logic                         daccess_o,
	output logic                         lane_active_o
);
	logic [3:0]  op;
	logic        is_fmt_c;
	logic        is_block;
	logic        is_strided;
	logic        is_scatter;
	logic [31:0] ptr;

	assign op         = instruction_i.mem.op_type;
	assign is_fmt_c   = instruction_i.mem.fmt == mem_pkg::FMT_C;
	assign is_block   = op inside {[mem_pkg::OP_BLOCK_LO:mem_pkg::OP_BLOCK_HI]};
	assign is_strided = op inside {[mem_pkg::OP_STRIDED_LO:mem_pkg::OP_STRIDED_HI]};
	assign is_scatter = op inside {[mem_pkg::OP_SCATTER_LO:mem_pkg::OP_SCATTER_HI]};

	always_comb
	begin
		if (is_strided)
			ptr = base_addr_i + strided_offset_i;
		else if (is_scatter)
			ptr = mem_pkg::lane_pick(result_i, reg_lane_select_i);
		else
			ptr = result_i[31:0];	// Scalar address or block base
	end

	assign daddress_o       = {ptr[31:6], 6'd0};
	assign cache_lane_nxt_o = ptr[5:2];

	// Lane 0 sits in the top mask bit
	assign lane_active_o = mask_i[~reg_lane_select_i];

	assign daccess_o = !flush_i && is_fmt_c
		&& (is_block || (op != mem_pkg::OP_CTRL && lane_active_o));
endmodule

// File: src/mem_pkg.sv
/*
 * Memory access stage definitions
 * Line geometry, op codes, the two views of a format-C word,
 * control register numbers and the lane pick helper
 */
package mem_pkg;
	localparam int LANES   = 16;
	localparam int WORD_W  = 32;
	localparam int LINE_W  = 512;
	localparam int MASK_W  = 64;	// One bit per byte of a line
	localparam int STRANDS = 4;

	localparam logic [29:0] CORE_ID = 30'd0;

	localparam logic [3:0] OP_BYTE       = 4'd0;
	localparam logic [3:0] OP_BYTE_S     = 4'd1;
	localparam logic [3:0] OP_HALF       = 4'd2;
	localparam logic [3:0] OP_HALF_S     = 4'd3;
	localparam logic [3:0] OP_WORD       = 4'd4;
	localparam logic [3:0] OP_WORD_S     = 4'd5;
	localparam logic [3:0] OP_CTRL       = 4'd6;
	localparam logic [3:0] OP_BLOCK_LO   = 4'd7;
	localparam logic [3:0] OP_BLOCK_HI   = 4'd9;
	localparam logic [3:0] OP_STRIDED_LO = 4'd10;
	localparam logic [3:0] OP_STRIDED_HI = 4'd12;
	localparam logic [3:0] OP_SCATTER_LO = 4'd13;
	localparam logic [3:0] OP_SCATTER_HI = 4'd15;

	localparam logic [1:0] FMT_C = 2'b10;

	localparam logic [4:0] CR_STRAND_ID = 5'd0;
	localparam logic [4:0] CR_TEST      = 5'd7;
	localparam logic [4:0] CR_STRAND_EN = 5'd30;
	localparam logic [4:0] CR_HALT      = 5'd31;

	// Format-C word, seen as a memory op or as a control register transfer
	typedef union packed {
		struct packed {
			logic [1:0]  fmt;
			logic        is_load;
			logic [3:0]  op_type;
			logic [24:0] rest;
		} mem;
		struct packed {
			logic [1:0]  fmt;
			logic        is_read;
			logic [3:0]  op_type;
			logic [19:0] pad;
			logic [4:0]  cr_index;
		} cr;
	} instr_u;

	// Word N of a line, lane 0 being the most significant word
	function automatic logic [WORD_W-1:0] lane_pick(
		input logic [LINE_W-1:0] line,
		input logic [3:0]        lane
	);
		return line[(LANES - 1 - int'(lane)) * WORD_W +: WORD_W];
	endfunction
endpackage
